// ==== dual_decode_cfg.svh ====
`ifndef DUAL_DECODE_CFG_SVH
`define DUAL_DECODE_CFG_SVH

// program counter loaded when reset is asserted.
`define DD_RESET_PC 32'h0000_0080

// extra cycles the testbench waits beyond its computed test length.
`define DD_TIMEOUT_MARGIN 20

`endif

// ==== dual_decode_pkg.sv ====
`default_nettype none

package dual_decode_pkg;

  // one 32-bit instruction or data word.
  typedef logic [31:0] word_t;

  typedef logic [31:0] addr_t; // byte address.

  typedef logic [4:0] reg_idx_t; // x0 to x31.

  // immediate after sign extension to the full word.
  typedef logic [31:0] imm_t;

  // coarse instruction classes seen by the issue logic.
  typedef enum logic [3:0] {
    class_alu,
    class_lui,
    class_auipc,
    class_jal,
    class_jalr,
    class_branch,
    class_load,
    class_store,
    class_fence,
    class_system,
    class_illegal
  } instr_class_e;

endpackage

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dual_decode_cfg.svh"

module fetch_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   fetch_valid,
  input  logic [63:0]            fetch_data,
  input  logic                   redirect,
  input  dual_decode_pkg::addr_t redirect_pc,
  output logic                   pair_valid,
  output dual_decode_pkg::addr_t pair_pc,
  output logic [63:0]            pair_data
);
  import dual_decode_pkg::*;

  addr_t pc;

  // a redirect wins over a fetch in the same cycle, so the word is dropped.
  assign pair_valid = fetch_valid & ~redirect;
  assign pair_pc    = pc;
  assign pair_data  = fetch_data; // slot 0 sits in the low half.

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc <= `DD_RESET_PC;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (fetch_valid) begin
      pc <= pc + 32'd8; // two instructions per fetch word.
    end
  end

endmodule

`default_nettype wire

// ==== instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  dual_decode_pkg::word_t        instr,
  output dual_decode_pkg::instr_class_e instr_class,
  output dual_decode_pkg::imm_t         imm,
  output dual_decode_pkg::reg_idx_t     rd,
  output dual_decode_pkg::reg_idx_t     rs1,
  output dual_decode_pkg::reg_idx_t     rs2,
  output logic                          wren,
  output logic                          rden1,
  output logic                          rden2,
  output logic                          legal
);
  import dual_decode_pkg::*;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_fence  = 7'b0001111;
  localparam logic [6:0] op_system = 7'b1110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  imm_t       imm_i;
  imm_t       imm_s;
  imm_t       imm_b;
  imm_t       imm_u;
  imm_t       imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    instr_class = class_illegal;
    imm         = '0;
    wren        = 1'b0;
    rden1       = 1'b0;
    rden2       = 1'b0;
    legal       = 1'b1;
    case (opcode)
      op_lui: begin
        instr_class = class_lui;
        imm         = imm_u;
        wren        = 1'b1;
      end
      op_auipc: begin
        instr_class = class_auipc;
        imm         = imm_u;
        wren        = 1'b1;
      end
      op_jal: begin
        instr_class = class_jal;
        imm         = imm_j;
        wren        = 1'b1;
      end
      op_jalr: begin
        instr_class = class_jalr;
        imm         = imm_i;
        wren        = 1'b1;
        rden1       = 1'b1;
      end
      op_branch: begin
        instr_class = class_branch;
        imm         = imm_b;
        rden1       = 1'b1;
        rden2       = 1'b1;
        legal       = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      op_load: begin
        instr_class = class_load;
        imm         = imm_i;
        wren        = 1'b1;
        rden1       = 1'b1;
        legal       = (funct3 != 3'b011) && (funct3 < 3'b110); // lb lh lw lbu lhu.
      end
      op_store: begin
        instr_class = class_store;
        imm         = imm_s;
        rden1       = 1'b1;
        rden2       = 1'b1;
        legal       = (funct3 <= 3'b010);
      end
      op_imm: begin
        instr_class = class_alu;
        imm         = imm_i;
        wren        = 1'b1;
        rden1       = 1'b1;
      end
      op_reg: begin
        instr_class = class_alu; // register form has no immediate.
        wren        = 1'b1;
        rden1       = 1'b1;
        rden2       = 1'b1;
      end
      op_fence: begin
        instr_class = class_fence;
        imm         = imm_i;
      end
      op_system: begin
        instr_class = class_system;
        imm         = imm_i;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
    // the all-zero word is reserved as illegal.
    if (instr == '0) begin
      legal = 1'b0;
    end
    if (!legal) begin
      wren  = 1'b0;
      rden1 = 1'b0;
      rden2 = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          pair_valid,
  input  dual_decode_pkg::addr_t        pair_pc,
  input  logic [63:0]                   pair_data,
  output logic                          dec_valid,
  output dual_decode_pkg::addr_t        slot0_pc,
  output dual_decode_pkg::instr_class_e slot0_class,
  output dual_decode_pkg::imm_t         slot0_imm,
  output dual_decode_pkg::reg_idx_t     slot0_rd,
  output dual_decode_pkg::reg_idx_t     slot0_rs1,
  output dual_decode_pkg::reg_idx_t     slot0_rs2,
  output logic                          slot0_wren,
  output logic                          slot0_rden1,
  output logic                          slot0_rden2,
  output logic                          slot0_exception,
  output dual_decode_pkg::addr_t        slot1_pc,
  output dual_decode_pkg::instr_class_e slot1_class,
  output dual_decode_pkg::imm_t         slot1_imm,
  output dual_decode_pkg::reg_idx_t     slot1_rd,
  output dual_decode_pkg::reg_idx_t     slot1_rs1,
  output dual_decode_pkg::reg_idx_t     slot1_rs2,
  output logic                          slot1_wren,
  output logic                          slot1_rden1,
  output logic                          slot1_rden2,
  output logic                          slot1_exception
);
  import dual_decode_pkg::*;

  instr_class_e d0_class;
  instr_class_e d1_class;
  imm_t         d0_imm;
  imm_t         d1_imm;
  reg_idx_t     d0_rd;
  reg_idx_t     d0_rs1;
  reg_idx_t     d0_rs2;
  reg_idx_t     d1_rd;
  reg_idx_t     d1_rs1;
  reg_idx_t     d1_rs2;
  logic         d0_wren;
  logic         d0_rden1;
  logic         d0_rden2;
  logic         d0_legal;
  logic         d1_wren;
  logic         d1_rden1;
  logic         d1_rden2;
  logic         d1_legal;

  instr_decoder decoder0_i (
    .instr(pair_data[31:0]), .instr_class(d0_class), .imm(d0_imm),
    .rd(d0_rd), .rs1(d0_rs1), .rs2(d0_rs2),
    .wren(d0_wren), .rden1(d0_rden1), .rden2(d0_rden2), .legal(d0_legal)
  );

  instr_decoder decoder1_i (
    .instr(pair_data[63:32]), .instr_class(d1_class), .imm(d1_imm),
    .rd(d1_rd), .rs1(d1_rs1), .rs2(d1_rs2),
    .wren(d1_wren), .rden1(d1_rden1), .rden2(d1_rden2), .legal(d1_legal)
  );

  always_ff @(posedge clock) begin
    if (!reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= pair_valid;
    end
  end

  // the slot fields only move when a pair arrives.
  always_ff @(posedge clock) begin
    if (pair_valid) begin
      slot0_pc        <= pair_pc;
      slot0_class     <= d0_legal ? d0_class : class_illegal;
      slot0_imm       <= d0_imm;
      slot0_rd        <= d0_rd;
      slot0_rs1       <= d0_rs1;
      slot0_rs2       <= d0_rs2;
      slot0_wren      <= d0_wren;
      slot0_rden1     <= d0_rden1;
      slot0_rden2     <= d0_rden2;
      slot0_exception <= ~d0_legal;
      slot1_pc        <= pair_pc + 32'd4; // second instruction of the word.
      slot1_class     <= d1_legal ? d1_class : class_illegal;
      slot1_imm       <= d1_imm;
      slot1_rd        <= d1_rd;
      slot1_rs1       <= d1_rs1;
      slot1_rs2       <= d1_rs2;
      slot1_wren      <= d1_wren;
      slot1_rden1     <= d1_rden1;
      slot1_rden2     <= d1_rden2;
      slot1_exception <= ~d1_legal;
    end
  end

endmodule

`default_nettype wire

// ==== issue_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_unit (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          dec_valid,
  input  dual_decode_pkg::addr_t        slot0_pc,
  input  dual_decode_pkg::instr_class_e slot0_class,
  input  dual_decode_pkg::imm_t         slot0_imm,
  input  dual_decode_pkg::reg_idx_t     slot0_rd,
  input  dual_decode_pkg::reg_idx_t     slot0_rs1,
  input  dual_decode_pkg::reg_idx_t     slot0_rs2,
  input  logic                          slot0_wren,
  input  logic                          slot0_rden1,
  input  logic                          slot0_rden2,
  input  logic                          slot0_exception,
  input  dual_decode_pkg::addr_t        slot1_pc,
  input  dual_decode_pkg::instr_class_e slot1_class,
  input  dual_decode_pkg::imm_t         slot1_imm,
  input  dual_decode_pkg::reg_idx_t     slot1_rd,
  input  dual_decode_pkg::reg_idx_t     slot1_rs1,
  input  dual_decode_pkg::reg_idx_t     slot1_rs2,
  input  logic                          slot1_wren,
  input  logic                          slot1_rden1,
  input  logic                          slot1_rden2,
  input  logic                          slot1_exception,
  output logic                          issue_valid,
  output logic                          dual_issue,
  output dual_decode_pkg::addr_t        issue0_pc,
  output dual_decode_pkg::instr_class_e issue0_class,
  output dual_decode_pkg::imm_t         issue0_imm,
  output dual_decode_pkg::reg_idx_t     issue0_rd,
  output dual_decode_pkg::reg_idx_t     issue0_rs1,
  output dual_decode_pkg::reg_idx_t     issue0_rs2,
  output logic                          issue0_exception,
  output dual_decode_pkg::addr_t        issue1_pc,
  output dual_decode_pkg::instr_class_e issue1_class,
  output dual_decode_pkg::imm_t         issue1_imm,
  output dual_decode_pkg::reg_idx_t     issue1_rd,
  output dual_decode_pkg::reg_idx_t     issue1_rs1,
  output dual_decode_pkg::reg_idx_t     issue1_rs2,
  output logic                          issue1_exception
);
  import dual_decode_pkg::*;

  logic raw_hazard;
  logic mem_conflict;
  logic serialize;
  logic pair_ok;

  function automatic logic is_memory(input instr_class_e c);
    return (c == class_load) || (c == class_store);
  endfunction

  // these classes change control flow or ordering and always issue alone.
  function automatic logic is_control(input instr_class_e c);
    return (c == class_jal) || (c == class_jalr) || (c == class_branch) ||
           (c == class_fence) || (c == class_system);
  endfunction

  // slot 1 may not read what slot 0 writes in the same cycle. x0 is never a dependency.
  assign raw_hazard = slot0_wren && (slot0_rd != 5'd0) &&
                      ((slot1_rden1 && (slot1_rs1 == slot0_rd)) ||
                       (slot1_rden2 && (slot1_rs2 == slot0_rd)));
  assign mem_conflict = is_memory(slot0_class) && is_memory(slot1_class); // one memory port.
  assign serialize    = is_control(slot0_class) || is_control(slot1_class);
  assign pair_ok      = ~(raw_hazard | mem_conflict | serialize |
                          slot0_exception | slot1_exception);

  always_ff @(posedge clock) begin
    if (!reset) begin
      issue_valid <= 1'b0;
      dual_issue  <= 1'b0;
    end else begin
      issue_valid <= dec_valid;
      dual_issue  <= dec_valid & pair_ok;
    end
  end

  always_ff @(posedge clock) begin
    if (dec_valid) begin
      issue0_pc        <= slot0_pc;
      issue0_class     <= slot0_class;
      issue0_imm       <= slot0_imm;
      issue0_rd        <= slot0_rd;
      issue0_rs1       <= slot0_rs1;
      issue0_rs2       <= slot0_rs2;
      issue0_exception <= slot0_exception;
      issue1_pc        <= slot1_pc;
      issue1_class     <= slot1_class;
      issue1_imm       <= slot1_imm;
      issue1_rd        <= slot1_rd;
      issue1_rs1       <= slot1_rs1;
      issue1_rs2       <= slot1_rs2;
      issue1_exception <= slot1_exception;
    end
  end

endmodule

`default_nettype wire

// ==== dual_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_decode_top (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          fetch_valid,
  input  logic [63:0]                   fetch_data,
  input  logic                          redirect,
  input  dual_decode_pkg::addr_t        redirect_pc,
  output logic                          issue_valid,
  output logic                          dual_issue,
  output dual_decode_pkg::addr_t        issue0_pc,
  output dual_decode_pkg::instr_class_e issue0_class,
  output dual_decode_pkg::imm_t         issue0_imm,
  output dual_decode_pkg::reg_idx_t     issue0_rd,
  output dual_decode_pkg::reg_idx_t     issue0_rs1,
  output dual_decode_pkg::reg_idx_t     issue0_rs2,
  output logic                          issue0_exception,
  output dual_decode_pkg::addr_t        issue1_pc,
  output dual_decode_pkg::instr_class_e issue1_class,
  output dual_decode_pkg::imm_t         issue1_imm,
  output dual_decode_pkg::reg_idx_t     issue1_rd,
  output dual_decode_pkg::reg_idx_t     issue1_rs1,
  output dual_decode_pkg::reg_idx_t     issue1_rs2,
  output logic                          issue1_exception
);
  import dual_decode_pkg::*;

  // fetch to decode.
  logic        pair_valid;
  addr_t       pair_pc;
  logic [63:0] pair_data;

  // decode to issue. names match the ports on both sides.
  logic         dec_valid;
  addr_t        slot0_pc;
  addr_t        slot1_pc;
  instr_class_e slot0_class;
  instr_class_e slot1_class;
  imm_t         slot0_imm;
  imm_t         slot1_imm;
  reg_idx_t     slot0_rd;
  reg_idx_t     slot0_rs1;
  reg_idx_t     slot0_rs2;
  reg_idx_t     slot1_rd;
  reg_idx_t     slot1_rs1;
  reg_idx_t     slot1_rs2;
  logic         slot0_wren;
  logic         slot0_rden1;
  logic         slot0_rden2;
  logic         slot0_exception;
  logic         slot1_wren;
  logic         slot1_rden1;
  logic         slot1_rden2;
  logic         slot1_exception;

  fetch_unit fetch_unit_i (.*);

  decode_stage decode_stage_i (.*);

  issue_unit issue_unit_i (.*);

endmodule

`default_nettype wire

// ==== dual_decode_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_decode_assertions (
  input logic                          clock,
  input logic                          reset,
  input logic                          fetch_valid,
  input logic                          redirect,
  input logic                          dec_valid,
  input logic                          issue_valid,
  input logic                          dual_issue,
  input dual_decode_pkg::addr_t        issue0_pc,
  input dual_decode_pkg::addr_t        issue1_pc,
  input dual_decode_pkg::instr_class_e issue0_class,
  input dual_decode_pkg::instr_class_e issue1_class,
  input logic                          issue0_exception,
  input logic                          issue1_exception
);
  import dual_decode_pkg::*;

  int fail_count = 0;

  reset_clears_valid: assert property (@(posedge clock)
    !reset |=> !dec_valid && !issue_valid && !dual_issue)
    else begin
      $error("valid flags were not cleared by reset");
      fail_count++;
    end

  // a fetch word issues exactly two cycles later, unless a redirect dropped it.
  issue_latency: assert property (@(posedge clock) disable iff (!reset)
    issue_valid == $past(fetch_valid && !redirect, 2))
    else begin
      $error("issue_valid did not follow an accepted fetch by two cycles");
      fail_count++;
    end

  slot1_follows_slot0: assert property (@(posedge clock) disable iff (!reset)
    issue_valid |-> issue1_pc == issue0_pc + 32'd4)
    else begin
      $error("slot 1 program counter is not slot 0 plus four");
      fail_count++;
    end

  exception_single_issue: assert property (@(posedge clock) disable iff (!reset)
    issue_valid && (issue0_exception || issue1_exception) |-> !dual_issue)
    else begin
      $error("a pair with an exception was dual issued");
      fail_count++;
    end

  illegal_means_exception: assert property (@(posedge clock) disable iff (!reset)
    issue_valid |-> ((issue0_class == class_illegal) == issue0_exception) &&
                    ((issue1_class == class_illegal) == issue1_exception))
    else begin
      $error("illegal class and exception flag disagree");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== tb_dual_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dual_decode_cfg.svh"

module tb_dual_decode;
  import dual_decode_pkg::*;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_fence  = 7'b0001111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam int reset_cycles = 4;
  localparam int fetch_total  = 21; // fetch words sent over all six tests.
  localparam int drain_cycles = 5;
  localparam int cycle_limit  = reset_cycles + fetch_total + 6 * drain_cycles +
                                `DD_TIMEOUT_MARGIN;

  // one instruction as the encoder built it, with the fields the ISA says it uses.
  typedef struct packed {
    word_t        word;
    instr_class_e cls;
    imm_t         imm;
    reg_idx_t     rd;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    logic         wr;
    logic         rd1;
    logic         rd2;
    logic         chk_imm;
  } instr_t;

  typedef struct packed {
    addr_t  pc;
    instr_t s0;
    instr_t s1;
    logic   dual;
  } pair_exp_t;

  logic         clock;
  logic         reset;
  logic         fetch_valid;
  logic [63:0]  fetch_data;
  logic         redirect;
  addr_t        redirect_pc;
  logic         issue_valid;
  logic         dual_issue;
  addr_t        issue0_pc;
  instr_class_e issue0_class;
  imm_t         issue0_imm;
  reg_idx_t     issue0_rd;
  reg_idx_t     issue0_rs1;
  reg_idx_t     issue0_rs2;
  logic         issue0_exception;
  addr_t        issue1_pc;
  instr_class_e issue1_class;
  imm_t         issue1_imm;
  reg_idx_t     issue1_rd;
  reg_idx_t     issue1_rs1;
  reg_idx_t     issue1_rs2;
  logic         issue1_exception;

  pair_exp_t   expected_q[$];
  addr_t       model_pc = `DD_RESET_PC;
  logic [31:0] rand_state = 32'h4713;
  int          error_count = 0;
  int          failures_seen = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;

  dual_decode_top dual_decode_top_i (.*);

  bind dual_decode_top dual_decode_assertions assertions_i (.*);

  initial clock = 1'b0;
  always #50 clock = ~clock;

  always @(posedge clock) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic reg_idx_t rand_reg();
    logic [31:0] r;
    r = next_rand();
    return r[31:27];
  endfunction

  function automatic logic [31:0] rand_word();
    return next_rand();
  endfunction

  function automatic instr_t make_i(input logic [6:0] op, input instr_class_e cls,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input reg_idx_t rs1, input logic [11:0] imm12,
                                    input logic uses_regs);
    instr_t t;
    t = '0;
    t.word = {imm12, rs1, f3, rd, op};
    t.cls = cls;
    t.imm = {{20{imm12[11]}}, imm12};
    t.rd = rd;
    t.rs1 = rs1;
    t.wr = uses_regs;
    t.rd1 = uses_regs;
    t.chk_imm = 1'b1;
    return t;
  endfunction

  function automatic instr_t make_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
    instr_t t;
    t = '0;
    t.word = {f7, rs2, rs1, f3, rd, 7'b0110011};
    t.cls = class_alu;
    t.rd = rd;
    t.rs1 = rs1;
    t.rs2 = rs2;
    t.wr = 1'b1;
    t.rd1 = 1'b1;
    t.rd2 = 1'b1;
    return t;
  endfunction

  function automatic instr_t make_s(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input logic [11:0] imm12);
    instr_t t;
    t = '0;
    t.word = {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
    t.cls = class_store;
    t.imm = {{20{imm12[11]}}, imm12};
    t.rs1 = rs1;
    t.rs2 = rs2;
    t.rd1 = 1'b1;
    t.rd2 = 1'b1;
    t.chk_imm = 1'b1;
    return t;
  endfunction

  function automatic instr_t make_b(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input logic [12:0] imm13);
    instr_t t;
    t = '0;
    t.word = {imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], 7'b1100011};
    t.cls = class_branch;
    t.imm = {{19{imm13[12]}}, imm13};
    t.rs1 = rs1;
    t.rs2 = rs2;
    t.rd1 = 1'b1;
    t.rd2 = 1'b1;
    t.chk_imm = 1'b1;
    return t;
  endfunction

  function automatic instr_t make_u(input logic [6:0] op, input instr_class_e cls,
                                    input reg_idx_t rd, input logic [19:0] imm20);
    instr_t t;
    t = '0;
    t.word = {imm20, rd, op};
    t.cls = cls;
    t.imm = {imm20, 12'b0};
    t.rd = rd;
    t.wr = 1'b1;
    t.chk_imm = 1'b1;
    return t;
  endfunction

  function automatic instr_t make_j(input reg_idx_t rd, input logic [20:0] imm21);
    instr_t t;
    t = '0;
    t.word = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, 7'b1101111};
    t.cls = class_jal;
    t.imm = {{11{imm21[20]}}, imm21};
    t.rd = rd;
    t.wr = 1'b1;
    t.chk_imm = 1'b1;
    return t;
  endfunction

  function automatic instr_t make_bad(input word_t word);
    instr_t t;
    t = '0;
    t.word = word;
    t.cls = class_illegal; // nothing else of an illegal word is defined.
    return t;
  endfunction

  function automatic instr_t rand_alu();
    logic [31:0] r;
    r = rand_word();
    return make_i(op_imm, class_alu, 3'b000, rand_reg(), rand_reg(), r[27:16], 1'b1);
  endfunction

  function automatic logic uses_memory_port(input instr_class_e c);
    return (c == class_load) || (c == class_store);
  endfunction

  function automatic logic forces_single_issue(input instr_class_e c);
    return (c == class_jal) || (c == class_jalr) || (c == class_branch) ||
           (c == class_fence) || (c == class_system) || (c == class_illegal);
  endfunction

  function automatic logic expect_dual(input instr_t a, input instr_t b);
    logic reads_a;
    reads_a = a.wr && (a.rd != 5'd0) &&
              ((b.rd1 && (b.rs1 == a.rd)) || (b.rd2 && (b.rs2 == a.rd)));
    if (reads_a || (uses_memory_port(a.cls) && uses_memory_port(b.cls))) begin
      return 1'b0;
    end
    return !forces_single_issue(a.cls) && !forces_single_issue(b.cls);
  endfunction

  task automatic idle_cycle();
    @(posedge clock);
    #10;
    fetch_valid = 1'b0;
    redirect    = 1'b0;
  endtask

  task automatic send_pair(input instr_t s0, input instr_t s1);
    pair_exp_t e;
    @(posedge clock);
    #10;
    fetch_valid = 1'b1;
    fetch_data  = {s1.word, s0.word}; // slot 0 in the low half.
    redirect    = 1'b0;
    e.pc   = model_pc;
    e.s0   = s0;
    e.s1   = s1;
    e.dual = expect_dual(s0, s1);
    expected_q.push_back(e);
    model_pc = model_pc + 32'd8;
  endtask

  // the word sent with the redirect is dropped, so nothing is expected from it.
  task automatic redirect_fetch(input instr_t s0, input instr_t s1, input addr_t target);
    @(posedge clock);
    #10;
    fetch_valid = 1'b1;
    fetch_data  = {s1.word, s0.word};
    redirect    = 1'b1;
    redirect_pc = target;
    model_pc    = target;
  endtask

  function automatic int total_failures();
    return error_count + dual_decode_top_i.assertions_i.fail_count;
  endfunction

  task automatic finish_test(input string name);
    int count;
    idle_cycle();
    while (expected_q.size() != 0) idle_cycle();
    idle_cycle();
    count = total_failures() - failures_seen;
    failures_seen = total_failures();
    if (count == 0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, count);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_slot(input int k, input addr_t pc_exp, input instr_t e,
                            input addr_t pc, input instr_class_e cls, input imm_t imm,
                            input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2,
                            input logic exc);
    string p;
    p = $sformatf("issue%0d_", k);
    check_value({p, "pc"}, pc, pc_exp);
    check_value({p, "class"}, 32'(cls), 32'(e.cls));
    check_value({p, "exception"}, 32'(exc), 32'(e.cls == class_illegal));
    if (e.chk_imm) check_value({p, "imm"}, imm, e.imm);
    if (e.wr) check_value({p, "rd"}, 32'(rd), 32'(e.rd));
    if (e.rd1) check_value({p, "rs1"}, 32'(rs1), 32'(e.rs1));
    if (e.rd2) check_value({p, "rs2"}, 32'(rs2), 32'(e.rs2));
  endtask

  // outputs settle after the rising edge, so they are compared at the falling edge.
  always @(negedge clock) begin
    pair_exp_t e;
    if (reset && issue_valid) begin
      if (expected_q.size() == 0) begin
        $display("issue_valid was set although no fetched pair was waiting to issue");
        error_count++;
      end else begin
        e = expected_q.pop_front();
        check_slot(0, e.pc, e.s0, issue0_pc, issue0_class, issue0_imm, issue0_rd,
                   issue0_rs1, issue0_rs2, issue0_exception);
        check_slot(1, e.pc + 32'd4, e.s1, issue1_pc, issue1_class, issue1_imm, issue1_rd,
                   issue1_rs1, issue1_rs2, issue1_exception);
        check_value("dual_issue", 32'(dual_issue), 32'(e.dual));
      end
    end
  end

  initial begin
    while (cycle_count < cycle_limit) @(posedge clock);
    $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    reg_idx_t    r;
    logic [31:0] w;
    reset       = 1'b0;
    fetch_valid = 1'b0;
    fetch_data  = '0;
    redirect    = 1'b0;
    redirect_pc = '0;
    repeat (reset_cycles) @(posedge clock);
    #10;
    reset = 1'b1;

    repeat (4) send_pair(rand_alu(), rand_alu());
    finish_test("pc sequence");

    w = rand_word();
    send_pair(make_u(op_lui, class_lui, rand_reg(), w[31:12]),
              make_u(op_auipc, class_auipc, rand_reg(), w[19:0]));
    w = rand_word();
    send_pair(make_j(rand_reg(), {w[31:12], 1'b0}),
              make_i(op_jalr, class_jalr, 3'b000, rand_reg(), rand_reg(), w[11:0], 1'b1));
    w = rand_word();
    send_pair(make_b(3'b001, rand_reg(), rand_reg(), {w[31:20], 1'b0}),
              make_i(op_load, class_load, 3'b010, rand_reg(), rand_reg(), w[11:0], 1'b1));
    w = rand_word();
    send_pair(make_s(3'b010, rand_reg(), rand_reg(), w[31:20]),
              make_i(op_imm, class_alu, 3'b100, rand_reg(), rand_reg(), w[11:0], 1'b1));
    send_pair(make_r(7'b0100000, rand_reg(), rand_reg(), 3'b000, rand_reg()),
              make_i(op_fence, class_fence, 3'b000, 5'd0, 5'd0, 12'h0ff, 1'b0));
    send_pair(make_i(op_system, class_system, 3'b000, 5'd0, 5'd0, 12'h001, 1'b0),
              rand_alu());
    finish_test("decoding");

    w = rand_word();
    send_pair(make_bad({w[24:0], 7'b1111111}), rand_alu());
    send_pair(rand_alu(), make_bad(32'h0000_0000));
    finish_test("illegal instructions");

    r = rand_reg() | 5'd1; // any nonzero destination.
    send_pair(make_i(op_imm, class_alu, 3'b000, r, rand_reg(), 12'h7f3, 1'b1),
              make_r(7'b0000000, rand_reg(), r, 3'b000, rand_reg()));
    send_pair(make_i(op_imm, class_alu, 3'b000, 5'd0, rand_reg(), 12'h7f3, 1'b1),
              make_r(7'b0000000, 5'd0, 5'd0, 3'b000, rand_reg()));
    finish_test("register dependency");

    w = rand_word();
    send_pair(make_i(op_load, class_load, 3'b000, rand_reg(), rand_reg(), w[11:0], 1'b1),
              make_s(3'b001, rand_reg(), rand_reg(), w[31:20]));
    send_pair(rand_alu(), make_b(3'b000, rand_reg(), rand_reg(), {w[23:12], 1'b0}));
    send_pair(make_i(op_system, class_system, 3'b000, 5'd0, 5'd0, 12'h000, 1'b0),
              rand_alu());
    // slot 0 writes one of x0 to x15 while slot 1 reads only x16 to x31.
    r = rand_reg();
    w = rand_word();
    send_pair(make_i(op_imm, class_alu, 3'b110, {1'b0, r[3:0]}, rand_reg(), w[11:0], 1'b1),
              make_r(7'b0000000, {1'b1, w[31:28]}, {1'b1, w[27:24]}, 3'b111, rand_reg()));
    finish_test("pairing restrictions");

    send_pair(rand_alu(), rand_alu());
    redirect_fetch(rand_alu(), rand_alu(), 32'h0000_1000);
    send_pair(rand_alu(), rand_alu());
    finish_test("redirect");

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && total_failures() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
dual_decode_pkg.sv
fetch_unit.sv
instr_decoder.sv
decode_stage.sv
issue_unit.sv
dual_decode_top.sv
dual_decode_assertions.sv
tb_dual_decode.sv

// ==== Bender.yml ====
package:
  name: dual_decode

sources:
  - include_dirs:
      - .
    files:
      - dual_decode_pkg.sv
      - fetch_unit.sv
      - instr_decoder.sv
      - decode_stage.sv
      - issue_unit.sv
      - dual_decode_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dual_decode_assertions.sv
      - tb_dual_decode.sv
